// ==== verilog/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    ////////////////////////////////////////
    // Frame and kernel geometry
    ////////////////////////////////////////

    // Fixed input frame, raster order
    localparam int IMG_W = 12;
    localparam int IMG_H = 12;

    // Square kernel side and taps per kernel
    localparam int K    = 5;
    localparam int TAPS = 25;

    // Parallel filter lanes
    localparam int NUM_FILTERS = 4;

    ////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////

    localparam int PIX_W  = 8;
    localparam int COEF_W = 8;
    // 25 products of 8x9 bits plus bias fit well inside 24 bits
    localparam int ACC_W  = 24;

    // Cycles from window valid to lane valid
    localparam int MAC_LAT = 7;

    // Counter and address field widths
    localparam int COL_W  = $clog2(IMG_W);
    localparam int ROW_W  = $clog2(IMG_H);
    localparam int FILT_W = $clog2(NUM_FILTERS);
    localparam int TAP_W  = $clog2(TAPS + 1);

    // Tap address that selects the bias instead of a weight
    localparam logic [TAP_W-1:0] BIAS_TAP = TAP_W'(TAPS);

    // Counter limits, last position and first interior position
    localparam logic [COL_W-1:0] COL_LAST  = COL_W'(IMG_W - 1);
    localparam logic [ROW_W-1:0] ROW_LAST  = ROW_W'(IMG_H - 1);
    localparam logic [COL_W-1:0] COL_FIRST = COL_W'(K - 1);
    localparam logic [ROW_W-1:0] ROW_FIRST = ROW_W'(K - 1);

    ////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////

    typedef logic        [PIX_W-1:0]  pixel_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // Indexed [row][col], row 0 oldest, col 0 leftmost
    typedef pixel_t [K-1:0][K-1:0] window_t;

    // Weight index is row*K + col, tap 12 is the center
    typedef struct packed {
        coef_t [TAPS-1:0] weights;
        coef_t            bias;
    } kernel_t;

    typedef kernel_t [NUM_FILTERS-1:0] kernel_vec_t;

    // One coefficient write, tap BIAS_TAP addresses the bias
    typedef struct packed {
        logic              we;
        logic [FILT_W-1:0] filt;
        logic [TAP_W-1:0]  tap;
        coef_t             data;
    } coef_wr_t;

    typedef acc_t [NUM_FILTERS-1:0] feature_vec_t;

endpackage

`default_nettype wire

// ==== verilog/coef_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module coef_bank (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  conv_pkg::coef_wr_t    i_coef,
    output conv_pkg::kernel_vec_t o_kernels
);

    // All weights and biases of every filter
    conv_pkg::kernel_vec_t kernels;

    ////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////

    // One field per strobe, addressed by filter and tap
    // Tap addresses above the bias are dropped
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            // Every filter starts as an all-zero kernel
            kernels <= '0;
        end else if (i_coef.we) begin
            if (i_coef.tap == conv_pkg::BIAS_TAP) begin
                // Bias slot
                kernels[i_coef.filt].bias <= i_coef.data;
            end else if (i_coef.tap < conv_pkg::BIAS_TAP) begin
                // Weight slot, row-major tap order
                kernels[i_coef.filt].weights[i_coef.tap] <= i_coef.data;
            end
        end
    end

    // Lanes see the register contents directly
    // New values are visible one cycle after the strobe
    assign o_kernels = kernels;

endmodule

`default_nettype wire

// ==== verilog/feature_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_window (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_pix_valid,
    input  conv_pkg::pixel_t  i_pix,
    output conv_pkg::window_t o_window,
    output logic              o_win_valid
);

    // Position of the next pixel to arrive
    logic [conv_pkg::COL_W-1:0] col_cnt;
    logic [conv_pkg::ROW_W-1:0] row_cnt;

    // Input stage, one accepted pixel with its column
    logic                       in_vld_q;
    logic                       in_int_q;
    conv_pkg::pixel_t           in_pix_q;
    logic [conv_pkg::COL_W-1:0] in_col_q;

    // Four previous rows, entry 0 is the oldest
    conv_pkg::pixel_t line_buf [conv_pkg::K-1][conv_pkg::IMG_W];

    // Column entering the window, index 0 is the oldest row
    conv_pkg::pixel_t [conv_pkg::K-1:0] new_col;

    conv_pkg::window_t window;
    logic              win_valid;

    ////////////////////////////////////////
    // Position counters
    ////////////////////////////////////////

    // Column wraps at the row end, row wraps at the frame end
    // The pixel after the last of a frame starts the next frame
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_pix_valid) begin
            if (col_cnt == conv_pkg::COL_LAST) begin
                col_cnt <= '0;
                if (row_cnt == conv_pkg::ROW_LAST) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Input stage
    ////////////////////////////////////////

    // Strobe and interior flag of the pixel just accepted
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_vld_q <= 1'b0;
            in_int_q <= 1'b0;
        end else begin
            in_vld_q <= i_pix_valid;
            // Full 5x5 neighborhood exists from row 4 and column 4 on
            in_int_q <= (col_cnt >= conv_pkg::COL_FIRST) &&
                        (row_cnt >= conv_pkg::ROW_FIRST);
        end
    end

    // Pixel and its column, captured with the strobe
    always_ff @(posedge i_clk) begin
        if (i_pix_valid) begin
            in_pix_q <= i_pix;
            in_col_q <= col_cnt;
        end
    end

    ////////////////////////////////////////
    // Line buffers
    ////////////////////////////////////////

    // Buffered rows r-4..r-1 of this column, then the new pixel
    always_comb begin
        for (int i = 0; i < conv_pkg::K - 1; i++) begin
            new_col[i] = line_buf[i][in_col_q];
        end
        new_col[conv_pkg::K-1] = in_pix_q;
    end

    // Each entry of the column moves up one row
    // The oldest pixel drops out, the new pixel goes to the last row
    always_ff @(posedge i_clk) begin
        if (in_vld_q) begin
            for (int i = 0; i < conv_pkg::K - 1; i++) begin
                line_buf[i][in_col_q] <= new_col[i+1];
            end
        end
    end

    ////////////////////////////////////////
    // Window register
    ////////////////////////////////////////

    // Shift left by one column and append the new column at the right
    always_ff @(posedge i_clk) begin
        if (in_vld_q) begin
            for (int r = 0; r < conv_pkg::K; r++) begin
                for (int c = 0; c < conv_pkg::K - 1; c++) begin
                    window[r][c] <= window[r][c+1];
                end
                window[r][conv_pkg::K-1] <= new_col[r];
            end
        end
    end

    // Pulse only when the shifted window is fully interior
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= in_vld_q & in_int_q;
        end
    end

    assign o_window    = window;
    assign o_win_valid = win_valid;

endmodule

`default_nettype wire

// ==== verilog/mac_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_tree (
    input  logic              i_clk,
    input  logic              i_rst,
    input  conv_pkg::window_t i_window,
    input  logic              i_win_valid,
    input  conv_pkg::kernel_t i_kernel,
    output conv_pkg::acc_t    o_feature,
    output logic              o_valid
);

    // Products, row-major like the weights
    conv_pkg::acc_t prod [conv_pkg::TAPS];

    // Adder tree, 25 -> 13 -> 7 -> 4 -> 2 -> 1
    conv_pkg::acc_t sum1 [13];
    conv_pkg::acc_t sum2 [7];
    conv_pkg::acc_t sum3 [4];
    conv_pkg::acc_t sum4 [2];
    conv_pkg::acc_t sum5;

    // Tree sum plus bias
    conv_pkg::acc_t result;

    // Valid bit per pipeline stage
    logic [conv_pkg::MAC_LAT-1:0] vld_sr;

    ////////////////////////////////////////
    // Multiply stage
    ////////////////////////////////////////

    // Signed weight times zero-extended pixel
    always_ff @(posedge i_clk) begin
        for (int r = 0; r < conv_pkg::K; r++) begin
            for (int c = 0; c < conv_pkg::K; c++) begin
                prod[r*conv_pkg::K+c] <=
                    conv_pkg::acc_t'(i_kernel.weights[r*conv_pkg::K+c]) *
                    conv_pkg::acc_t'($signed({1'b0, i_window[r][c]}));
            end
        end
    end

    ////////////////////////////////////////
    // Adder stages
    ////////////////////////////////////////

    // Pairwise sums, an odd last term passes to the next stage as is
    always_ff @(posedge i_clk) begin
        // 25 -> 13
        for (int j = 0; j < 12; j++) begin
            sum1[j] <= prod[2*j] + prod[2*j+1];
        end
        sum1[12] <= prod[24];

        // 13 -> 7
        for (int j = 0; j < 6; j++) begin
            sum2[j] <= sum1[2*j] + sum1[2*j+1];
        end
        sum2[6] <= sum1[12];

        // 7 -> 4
        for (int j = 0; j < 3; j++) begin
            sum3[j] <= sum2[2*j] + sum2[2*j+1];
        end
        sum3[3] <= sum2[6];

        // 4 -> 2
        for (int j = 0; j < 2; j++) begin
            sum4[j] <= sum3[2*j] + sum3[2*j+1];
        end

        // 2 -> 1
        sum5 <= sum4[0] + sum4[1];
    end

    ////////////////////////////////////////
    // Bias stage
    ////////////////////////////////////////

    // Coefficients are static during a frame
    always_ff @(posedge i_clk) begin
        result <= sum5 + conv_pkg::acc_t'(i_kernel.bias);
    end

    // Valid follows its window through every stage
    // Up to MAC_LAT windows may be in flight
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[conv_pkg::MAC_LAT-2:0], i_win_valid};
        end
    end

    assign o_feature = result;
    assign o_valid   = vld_sr[conv_pkg::MAC_LAT-1];

endmodule

`default_nettype wire

// ==== verilog/conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_top (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  conv_pkg::coef_wr_t     i_coef,
    input  logic                   i_pix_valid,
    input  conv_pkg::pixel_t       i_pix,
    output logic                   o_valid,
    output conv_pkg::feature_vec_t o_features
);

    // Coefficients of all filters
    conv_pkg::kernel_vec_t kernels;

    // Shared window and its strobe
    conv_pkg::window_t window;
    logic              win_valid;

    // Per-lane valid, all lanes run in lockstep
    logic [conv_pkg::NUM_FILTERS-1:0] lane_valid;

    ////////////////////////////////////////
    // Configuration and window
    ////////////////////////////////////////

    coef_bank i_coef_bank (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_coef    (i_coef),
        .o_kernels (kernels)
    );

    feature_window i_feature_window (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_window    (window),
        .o_win_valid (win_valid)
    );

    ////////////////////////////////////////
    // Filter lanes
    ////////////////////////////////////////

    // Lane f takes kernel f and drives output slot f
    for (genvar f = 0; f < conv_pkg::NUM_FILTERS; f++) begin : g_lane
        mac_tree i_mac_tree (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_window    (window),
            .i_win_valid (win_valid),
            .i_kernel    (kernels[f]),
            .o_feature   (o_features[f]),
            .o_valid     (lane_valid[f])
        );
    end

    // Lane 0 stands for all lanes
    assign o_valid = lane_valid[0];

endmodule

`default_nettype wire

// ==== dv/conv_ref.svh ====
`ifndef CONV_REF_SVH
`define CONV_REF_SVH
`default_nettype none

////////////////////////////////////////
// Reference model
////////////////////////////////////////

// Whole frame, indexed [row][col] like the pixel stream
typedef conv_pkg::pixel_t [conv_pkg::IMG_H-1:0][conv_pkg::IMG_W-1:0] image_t;

// 5x5 neighborhood with top-left pixel (r, c), weighted, plus bias
// Weight index is row*K + col inside the neighborhood
function automatic conv_pkg::acc_t window_sum_model(
    input image_t            img,
    input conv_pkg::kernel_t kern,
    input int                r,
    input int                c
);
    longint acc;
    acc = longint'(kern.bias);
    for (int kr = 0; kr < conv_pkg::K; kr++) begin
        for (int kc = 0; kc < conv_pkg::K; kc++) begin
            // Signed weight, unsigned pixel
            acc += longint'(kern.weights[kr*conv_pkg::K+kc]) * longint'(img[r+kr][c+kc]);
        end
    end
    return conv_pkg::acc_t'(acc);
endfunction

// Center tap only, so output (r, c) is pixel (r+2, c+2) plus bias
function automatic conv_pkg::acc_t center_pixel_model(
    input image_t img,
    input int     bias,
    input int     r,
    input int     c
);
    return conv_pkg::acc_t'(int'(img[r+conv_pkg::K/2][c+conv_pkg::K/2]) + bias);
endfunction

`default_nettype wire
`endif

// ==== dv/conv_tb.sv ====
`timescale 1ns/1ps
`include "conv_ref.svh"
`default_nettype none

module conv_tb;

    localparam int SEED          = 32'h6583_ad58;
    localparam int MAX_CASES     = 16;
    localparam int OUT_PER_FRAME = (conv_pkg::IMG_H - conv_pkg::K + 1) *
                                   (conv_pkg::IMG_W - conv_pkg::K + 1);
    localparam int TIMEOUT_MARGIN = 200;
    // Edges from accepting the last pixel of a window to its output pulse
    localparam int OUT_LAT = 8;

    logic                   i_clk;
    logic                   i_rst;
    conv_pkg::coef_wr_t     i_coef;
    logic                   i_pix_valid;
    conv_pkg::pixel_t       i_pix;
    logic                   o_valid;
    conv_pkg::feature_vec_t o_features;

    // Case table from the file
    int c_kind [MAX_CASES];
    int c_val  [MAX_CASES];
    int c_w    [MAX_CASES];
    int c_b    [MAX_CASES];
    int c_mode [MAX_CASES];
    int c_exp  [MAX_CASES];
    int n_cases = 0;

    // Expected outputs in raster order of positions
    conv_pkg::feature_vec_t exp_q [$];
    conv_pkg::feature_vec_t exp_fv;

    int cyc        = 0;
    int limit      = 0;
    int pulses     = 0;
    int pix_seen   = 0;
    int accept_cyc = 0;
    bit first_gapfree;

    conv_top i_dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_coef      (i_coef),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_valid     (o_valid),
        .o_features  (o_features)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Edges since time zero
    always @(posedge i_clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Columns: kind, value (hex), weight, bias, mode, expected
    task automatic read_cases();
        int    fd;
        string line;
        int    kind, val, w, b, mode, expv;
        fd = $fopen("dv/conv_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file dv/conv_cases.txt");
            $display("Regression failed");
            $fatal(1, "missing case file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Comment and blank lines do not scan
                if ($sscanf(line, "%d %h %d %d %d %d", kind, val, w, b, mode, expv) == 6 &&
                    n_cases < MAX_CASES) begin
                    c_kind[n_cases] = kind;
                    c_val[n_cases]  = val;
                    c_w[n_cases]    = w;
                    c_b[n_cases]    = b;
                    c_mode[n_cases] = mode;
                    c_exp[n_cases]  = expv;
                    n_cases++;
                end
            end
            $fclose(fd);
            if (n_cases == 0) begin
                $display("The case file holds no test cases");
                $display("Regression failed");
                $fatal(1, "empty case file");
            end
        end
    endtask

    task automatic apply_reset();
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
    endtask

    // Kind 0 uniform, kind 1 center tap, otherwise random per filter
    function automatic conv_pkg::kernel_vec_t make_kernels(input int kind, input int w,
                                                           input int b);
        conv_pkg::kernel_vec_t kv;
        kv = '0;
        for (int f = 0; f < conv_pkg::NUM_FILTERS; f++) begin
            for (int t = 0; t < conv_pkg::TAPS; t++) begin
                if (kind == 0) begin
                    kv[f].weights[t] = conv_pkg::coef_t'(w);
                end else if (kind != 1) begin
                    kv[f].weights[t] = conv_pkg::coef_t'($urandom());
                end
            end
            if (kind == 1) begin
                kv[f].weights[conv_pkg::TAPS/2] = 8'sd1;
            end
            kv[f].bias = (kind > 1) ? conv_pkg::coef_t'($urandom()) : conv_pkg::coef_t'(b);
        end
        return kv;
    endfunction

    // Uniform frame of val, or random pixels salted with val
    function automatic image_t make_image(input int kind, input int val);
        image_t img;
        for (int r = 0; r < conv_pkg::IMG_H; r++) begin
            for (int c = 0; c < conv_pkg::IMG_W; c++) begin
                img[r][c] = (kind == 0) ? conv_pkg::pixel_t'(val)
                                        : conv_pkg::pixel_t'($urandom() ^ val);
            end
        end
        return img;
    endfunction

    // One strobe per field, tap TAPS is the bias
    task automatic write_kernels(input conv_pkg::kernel_vec_t kv);
        conv_pkg::coef_wr_t wr;
        for (int f = 0; f < conv_pkg::NUM_FILTERS; f++) begin
            for (int t = 0; t <= conv_pkg::TAPS; t++) begin
                wr.we   = 1'b1;
                wr.filt = conv_pkg::FILT_W'(f);
                wr.tap  = conv_pkg::TAP_W'(t);
                wr.data = (t == conv_pkg::TAPS) ? kv[f].bias : kv[f].weights[t];
                @(posedge i_clk);
                i_coef <= wr;
            end
        end
        @(posedge i_clk);
        i_coef <= '0;
    endtask

    task automatic push_expected(input image_t img, input conv_pkg::kernel_vec_t kv,
                                 input int i);
        conv_pkg::feature_vec_t fv;
        for (int r = 0; r <= conv_pkg::IMG_H - conv_pkg::K; r++) begin
            for (int c = 0; c <= conv_pkg::IMG_W - conv_pkg::K; c++) begin
                for (int f = 0; f < conv_pkg::NUM_FILTERS; f++) begin
                    if (c_kind[i] == 0) begin
                        fv[f] = conv_pkg::acc_t'(c_exp[i]);
                    end else if (c_kind[i] == 1) begin
                        fv[f] = center_pixel_model(img, c_b[i], r, c);
                    end else begin
                        fv[f] = window_sum_model(img, kv[f], r, c);
                    end
                end
                exp_q.push_back(fv);
            end
        end
    endtask

    // Raster order, optional idle cycles before a pixel
    // Valid stays high at the frame end so frames run back to back
    task automatic stream_frame(input image_t img, input bit gaps);
        int idle;
        for (int r = 0; r < conv_pkg::IMG_H; r++) begin
            for (int c = 0; c < conv_pkg::IMG_W; c++) begin
                idle = 0;
                if (gaps && ($urandom() % 4) == 0) begin
                    idle = 1 + int'($urandom() % 2);
                end
                repeat (idle) begin
                    @(posedge i_clk);
                    i_pix_valid <= 1'b0;
                end
                @(posedge i_clk);
                i_pix_valid <= 1'b1;
                i_pix       <= img[r][c];
            end
        end
    endtask

    // Last pixel lands on the first edge, its output OUT_LAT edges later
    // The extra edges watch for stray pulses
    task automatic drain_outputs();
        @(posedge i_clk);
        i_pix_valid <= 1'b0;
        repeat (OUT_LAT + conv_pkg::MAC_LAT + 4) @(posedge i_clk);
    endtask

    // Mode bit 0 adds gaps, bit 1 streams two frames
    task automatic run_case(input int i);
        conv_pkg::kernel_vec_t kv;
        image_t                img;
        int                    frames;
        int                    start;
        kv = make_kernels(c_kind[i], c_w[i], c_b[i]);
        write_kernels(kv);
        frames = ((c_mode[i] & 2) != 0) ? 2 : 1;
        start  = pulses;
        for (int fr = 0; fr < frames; fr++) begin
            img = make_image(c_kind[i], c_val[i]);
            push_expected(img, kv, i);
            stream_frame(img, (c_mode[i] & 1) != 0);
        end
        drain_outputs();
        check_value($sformatf("output count of case %0d", i), pulses - start,
                    frames * OUT_PER_FRAME);
    endtask

    ////////////////////////////////////////
    // Output checker
    ////////////////////////////////////////

    // Negedge sampling, DUT outputs are settled here
    always @(negedge i_clk) begin
        if (i_pix_valid) begin
            // Pixel (4,4) of the first frame lands on the next edge
            if (pix_seen == (conv_pkg::K - 1) * conv_pkg::IMG_W + conv_pkg::K - 1) begin
                accept_cyc = cyc + 1;
            end
            pix_seen++;
        end
        if (o_valid) begin
            if (exp_q.size() == 0) begin
                $display("Output pulse at %0t ns arrived with no output expected", $time);
                $display("Regression failed");
                $fatal(1, "unexpected output");
            end else begin
                if (pulses == 0 && first_gapfree) begin
                    check_value("edge of the first output", cyc, accept_cyc + OUT_LAT);
                end
                exp_fv = exp_q.pop_front();
                for (int f = 0; f < conv_pkg::NUM_FILTERS; f++) begin
                    check_value($sformatf("filter %0d output %0d", f, pulses),
                                int'(o_features[f]), int'(exp_fv[f]));
                end
                pulses++;
            end
        end
    end

    // Four frame lengths per case leaves room for gaps and coefficient writes
    initial begin
        @(posedge i_clk);
        while (cyc < limit) @(posedge i_clk);
        $display("Timeout, the run did not finish within %0d cycles", limit);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        i_rst       = 1'b1;
        i_coef      = '0;
        i_pix_valid = 1'b0;
        i_pix       = '0;
        void'($urandom(SEED));
        read_cases();
        limit = n_cases * 4 * conv_pkg::IMG_W * conv_pkg::IMG_H + TIMEOUT_MARGIN;
        first_gapfree = ((c_mode[0] & 1) == 0);
        apply_reset();
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/conv_cases.txt ====
# kind value weight bias mode expected
# kind 0 uniform, 1 center tap, 2 random; value hex; mode bit 0 gaps, bit 1 two frames
0 0a 3 -7 0 743
0 ff -128 127 0 -815873
1 5a 0 -3 0 0
2 3c 0 0 0 0
0 ff 127 -128 1 809497
1 00 0 9 1 0
2 c3 0 0 1 0
0 01 1 0 2 25
2 99 0 0 2 0
2 17 0 0 3 0
0 00 50 5 3 5

// ==== all.f ====
+incdir+dv
verilog/conv_pkg.sv
verilog/coef_bank.sv
verilog/feature_window.sv
verilog/mac_tree.sv
verilog/conv_top.sv
dv/conv_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator and run, the exit status tells pass or fail
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module conv_tb -f all.f -o conv_sim \
    && ./obj_dir/conv_sim \
    || exit 1
